//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_chip8
FILELIST  ?= sim.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= -Wno-fatal

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only --timing $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

sim:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP)

clean:
	rm -rf $(BUILD_DIR)

//--- alu.sv
`timescale 1ns/1ps

module alu
   import chip8_pkg::*;
(
   input  alu_op_t op,
   input  byte_t   vx,
   input  byte_t   vy,
   output byte_t   result,
   output logic    flag,
   output logic    writes_flag
);

   logic [8:0] sum;

   assign sum = {1'b0, vx} + {1'b0, vy};

   always_comb
   begin
      result      = vx;
      flag        = 1'b0;
      writes_flag = 1'b0;
      case (op)
         ALU_LD:  result = vy;
         ALU_OR:  result = vx | vy;
         ALU_AND: result = vx & vy;
         ALU_XOR: result = vx ^ vy;
         ALU_ADD:
         begin
            result      = sum[7:0];
            flag        = sum[8]; // carry out
            writes_flag = 1'b1;
         end
         ALU_SUB:
         begin
            result      = vx - vy;
            flag        = vx > vy; // no borrow
            writes_flag = 1'b1;
         end
         ALU_SHR:
         begin
            result      = vx >> 1;
            flag        = vx[0];
            writes_flag = 1'b1;
         end
         ALU_SUBN:
         begin
            result      = vy - vx;
            flag        = vy > vx;
            writes_flag = 1'b1;
         end
         ALU_SHL:
         begin
            result      = vx << 1;
            flag        = vx[7];
            writes_flag = 1'b1;
         end
         default: result = vx;
      endcase
   end

endmodule

//--- call_stack.sv
`timescale 1ns/1ps

module call_stack
   import chip8_pkg::*;
(
   input  logic  clk,
   input  logic  rst_n,
   input  logic  push,
   input  logic  pop,
   input  addr_t ret_addr,
   output addr_t top
);

   addr_t entries [STACK_DEPTH];
   sp_t   sp;
   sp_t   sp_below;

   assign sp_below = sp - 1'b1; // wraps on underflow
   assign top      = entries[sp_below];

   always_ff @(posedge clk)
   begin
      if (!rst_n)
      begin
         sp <= '0;
      end
      else if (push)
      begin
         sp <= sp + 1'b1;
      end
      else if (pop)
      begin
         sp <= sp_below;
      end
   end

   always_ff @(posedge clk)
   begin
      if (push)
      begin
         entries[sp] <= ret_addr;
      end
   end

endmodule

//--- chip8_core.sv
`timescale 1ns/1ps

module chip8_core
   import chip8_pkg::*;
(
   input  logic  clk,
   input  logic  rst_n,
   input  logic  run,
   input  logic  load_we,
   input  addr_t load_addr,
   input  byte_t load_data,
   output wb_t   wb,
   output addr_t pc
);

   addr_t    mem_raddr;
   byte_t    mem_rdata;
   instr_t   instr;
   logic     exec;
   logic     flag_cycle;
   logic     skip;
   logic     jump;
   logic     call;
   logic     ret;
   logic     flag_pending;
   addr_t    jump_target;
   addr_t    stack_top;
   addr_t    ret_addr;
   logic     push;
   logic     pop;
   reg_idx_t x_idx;
   reg_idx_t y_idx;
   byte_t    vx;
   byte_t    vy;

   program_mem program_mem_i (
      .clk   (clk),
      .we    (load_we),
      .waddr (load_addr),
      .wdata (load_data),
      .raddr (mem_raddr),
      .rdata (mem_rdata)
   );

   call_stack call_stack_i (
      .clk      (clk),
      .rst_n    (rst_n),
      .push     (push),
      .pop      (pop),
      .ret_addr (ret_addr),
      .top      (stack_top)
   );

   reg_file reg_file_i (
      .clk      (clk),
      .rd_a_idx (x_idx),
      .rd_b_idx (y_idx),
      .rd_a     (vx),
      .rd_b     (vy),
      .wb       (wb)
   );

   sequencer sequencer_i (
      .clk          (clk),
      .rst_n        (rst_n),
      .run          (run),
      .mem_rdata    (mem_rdata),
      .mem_raddr    (mem_raddr),
      .instr        (instr),
      .exec         (exec),
      .flag_cycle   (flag_cycle),
      .skip         (skip),
      .jump         (jump),
      .call         (call),
      .ret          (ret),
      .flag_pending (flag_pending),
      .jump_target  (jump_target),
      .stack_top    (stack_top),
      .push         (push),
      .pop          (pop),
      .ret_addr     (ret_addr),
      .pc           (pc)
   );

   exec_unit exec_unit_i (
      .clk          (clk),
      .rst_n        (rst_n),
      .exec         (exec),
      .flag_cycle   (flag_cycle),
      .instr        (instr),
      .vx           (vx),
      .vy           (vy),
      .x_idx        (x_idx),
      .y_idx        (y_idx),
      .wb           (wb),
      .skip         (skip),
      .jump         (jump),
      .call         (call),
      .ret          (ret),
      .flag_pending (flag_pending),
      .jump_target  (jump_target)
   );

endmodule

//--- chip8_pkg.sv
package chip8_pkg;

   localparam int ADDR_W      = 12;
   localparam int MEM_DEPTH   = 2 ** ADDR_W;
   localparam int REG_IDX_W   = 4;
   localparam int NUM_REGS    = 2 ** REG_IDX_W;
   localparam int STACK_DEPTH = 16;
   localparam int SP_W        = $clog2(STACK_DEPTH);

   typedef logic [ADDR_W-1:0]    addr_t;
   typedef logic [7:0]           byte_t;
   typedef logic [REG_IDX_W-1:0] reg_idx_t;
   typedef logic [15:0]          instr_t;
   typedef logic [SP_W-1:0]      sp_t;

   localparam addr_t       PC_START = 12'h200;
   localparam reg_idx_t    FLAG_REG = 4'hF;    // VF
   localparam logic [11:0] RET_WORD = 12'h0EE; // low 12 bits of 00EE

   // top nibble of the instruction word
   typedef enum logic [3:0] {
      SYS      = 4'h0,
      JP       = 4'h1,
      CALL     = 4'h2,
      SE_BYTE  = 4'h3,
      SNE_BYTE = 4'h4,
      SE_REG   = 4'h5,
      LD_BYTE  = 4'h6,
      ADD_BYTE = 4'h7,
      ALU      = 4'h8,
      OTHER    = 4'hF
   } opclass_t;

   typedef enum logic [3:0] {
      ALU_LD,
      ALU_OR,
      ALU_AND,
      ALU_XOR,
      ALU_ADD,
      ALU_SUB,
      ALU_SHR,
      ALU_SUBN,
      ALU_SHL,
      ALU_NONE
   } alu_op_t;

   typedef enum logic [2:0] {
      IDLE,
      FETCH_HI,
      FETCH_LO,
      EXEC,
      FLAG
   } seq_state_t;

   typedef struct packed {
      logic     valid;
      reg_idx_t idx;
      byte_t    value;
   } wb_t;

endpackage

//--- exec_unit.sv
`timescale 1ns/1ps

module exec_unit
   import chip8_pkg::*;
(
   input  logic     clk,
   input  logic     rst_n,
   input  logic     exec,
   input  logic     flag_cycle,
   input  instr_t   instr,
   input  byte_t    vx,
   input  byte_t    vy,
   output reg_idx_t x_idx,
   output reg_idx_t y_idx,
   output wb_t      wb,
   output logic     skip,
   output logic     jump,
   output logic     call,
   output logic     ret,
   output logic     flag_pending,
   output addr_t    jump_target
);

   opclass_t opclass;
   alu_op_t  alu_op;
   byte_t    kk;
   byte_t    alu_result;
   logic     alu_flag;
   logic     alu_writes_flag;
   logic     cond_hit;
   logic     flag_hold;
   logic     wb_valid;
   reg_idx_t wb_idx;
   byte_t    wb_value;
   wb_t      wb_next;

   assign x_idx       = instr[11:8];
   assign y_idx       = instr[7:4];
   assign kk          = instr[7:0];
   assign jump_target = instr[11:0];

   always_comb
   begin
      case (instr[15:12])
         4'h0:    opclass = SYS;
         4'h1:    opclass = JP;
         4'h2:    opclass = CALL;
         4'h3:    opclass = SE_BYTE;
         4'h4:    opclass = SNE_BYTE;
         4'h5:    opclass = SE_REG;
         4'h6:    opclass = LD_BYTE;
         4'h7:    opclass = ADD_BYTE;
         4'h8:    opclass = ALU;
         default: opclass = OTHER; // runs as a no-op
      endcase
      case (instr[3:0])
         4'h0:    alu_op = ALU_LD;
         4'h1:    alu_op = ALU_OR;
         4'h2:    alu_op = ALU_AND;
         4'h3:    alu_op = ALU_XOR;
         4'h4:    alu_op = ALU_ADD;
         4'h5:    alu_op = ALU_SUB;
         4'h6:    alu_op = ALU_SHR;
         4'h7:    alu_op = ALU_SUBN;
         4'hE:    alu_op = ALU_SHL;
         default: alu_op = ALU_NONE;
      endcase
   end

   alu alu_i (
      .op          (alu_op),
      .vx          (vx),
      .vy          (vy),
      .result      (alu_result),
      .flag        (alu_flag),
      .writes_flag (alu_writes_flag)
   );

   always_comb
   begin
      case (opclass)
         SE_BYTE:  cond_hit = vx == kk;
         SNE_BYTE: cond_hit = vx != kk;
         SE_REG:   cond_hit = vx == vy;
         default:  cond_hit = 1'b0;
      endcase
   end

   assign skip         = exec && cond_hit;
   assign jump         = exec && (opclass == JP || opclass == CALL);
   assign call         = exec && opclass == CALL;
   assign ret          = exec && opclass == SYS && instr[11:0] == RET_WORD;
   assign flag_pending = exec && opclass == ALU && alu_writes_flag;

   always_comb
   begin
      wb_next.valid = 1'b0;
      wb_next.idx   = x_idx;
      wb_next.value = kk;
      case (opclass)
         LD_BYTE:  wb_next.valid = exec;
         ADD_BYTE:
         begin
            wb_next.valid = exec; // VF untouched
            wb_next.value = vx + kk;
         end
         ALU:
         begin
            wb_next.valid = exec && alu_op != ALU_NONE;
            wb_next.value = alu_result;
         end
         default: wb_next.valid = 1'b0;
      endcase
   end

   always_ff @(posedge clk)
   begin
      if (!rst_n)
      begin
         wb_valid <= 1'b0;
      end
      else
      begin
         wb_valid <= flag_cycle || wb_next.valid;
      end
   end

   always_ff @(posedge clk)
   begin
      if (flag_cycle)
      begin
         wb_idx   <= FLAG_REG;
         wb_value <= byte_t'(flag_hold);
      end
      else
      begin
         wb_idx   <= wb_next.idx;
         wb_value <= wb_next.value;
      end
      if (flag_pending)
      begin
         flag_hold <= alu_flag; // written to VF one cycle later
      end
   end

   assign wb = '{valid: wb_valid, idx: wb_idx, value: wb_value};

endmodule

//--- program_mem.sv
`timescale 1ns/1ps

module program_mem
   import chip8_pkg::*;
(
   input  logic  clk,
   input  logic  we,
   input  addr_t waddr,
   input  byte_t wdata,
   input  addr_t raddr,
   output byte_t rdata
);

   byte_t mem [MEM_DEPTH];

   always_ff @(posedge clk)
   begin
      if (we)
      begin
         mem[waddr] <= wdata;
      end
      rdata <= mem[raddr]; // data one cycle after address
   end

endmodule

//--- reg_file.sv
`timescale 1ns/1ps

module reg_file
   import chip8_pkg::*;
(
   input  logic     clk,
   input  reg_idx_t rd_a_idx,
   input  reg_idx_t rd_b_idx,
   output byte_t    rd_a,
   output byte_t    rd_b,
   input  wb_t      wb
);

   byte_t regs [NUM_REGS];

   // V0..VF, VF doubles as the flag register
   assign rd_a = regs[rd_a_idx];
   assign rd_b = regs[rd_b_idx];

   always_ff @(posedge clk)
   begin
      if (wb.valid)
      begin
         regs[wb.idx] <= wb.value;
      end
   end

endmodule

//--- sequencer.sv
`timescale 1ns/1ps

module sequencer
   import chip8_pkg::*;
(
   input  logic   clk,
   input  logic   rst_n,
   input  logic   run,
   input  byte_t  mem_rdata,
   output addr_t  mem_raddr,
   output instr_t instr,
   output logic   exec,
   output logic   flag_cycle,
   input  logic   skip,
   input  logic   jump,
   input  logic   call,
   input  logic   ret,
   input  logic   flag_pending,
   input  addr_t  jump_target,
   input  addr_t  stack_top,
   output logic   push,
   output logic   pop,
   output addr_t  ret_addr,
   output addr_t  pc
);

   seq_state_t state;
   seq_state_t state_next;
   byte_t      instr_hi;

   assign exec       = state == EXEC;
   assign flag_cycle = state == FLAG;
   assign mem_raddr  = (state == FETCH_LO) ? pc + 12'd1 : pc;
   assign instr      = {instr_hi, mem_rdata}; // low byte straight off the RAM
   assign push       = exec && call;
   assign pop        = exec && ret;
   assign ret_addr   = pc; // already past the CALL in EXEC

   always_comb
   begin
      state_next = state;
      case (state)
         IDLE:     state_next = FETCH_HI;
         FETCH_HI: state_next = FETCH_LO;
         FETCH_LO: state_next = EXEC;
         EXEC:     state_next = flag_pending ? FLAG : FETCH_HI;
         FLAG:     state_next = FETCH_HI;
         default:  state_next = IDLE;
      endcase
      if (!run)
      begin
         state_next = IDLE;
      end
   end

   always_ff @(posedge clk)
   begin
      if (!rst_n)
      begin
         state <= IDLE;
         pc    <= PC_START;
      end
      else
      begin
         state <= state_next;
         if (!run)
         begin
            pc <= PC_START;
         end
         else if (state == FETCH_LO)
         begin
            pc <= pc + 12'd2;
         end
         else if (exec)
         begin
            if (jump)
            begin
               pc <= jump_target;
            end
            else if (ret)
            begin
               pc <= stack_top;
            end
            else if (skip)
            begin
               pc <= pc + 12'd2; // step over next instruction
            end
         end
      end
   end

   always_ff @(posedge clk)
   begin
      if (state == FETCH_LO)
      begin
         instr_hi <= mem_rdata;
      end
   end

endmodule

//--- sim.f
chip8_pkg.sv
program_mem.sv
call_stack.sv
reg_file.sv
alu.sv
exec_unit.sv
sequencer.sv
chip8_core.sv
tb_chip8.sv

//--- tb_chip8.sv
`timescale 1ns/1ps

module tb_chip8
   import chip8_pkg::*;
();

   localparam int NUM_TESTS      = 8;
   localparam int MAX_WORDS      = 16;
   localparam int MAX_WRITES     = 10;
   localparam int QUIET_CYCLES   = 8;
   localparam int TIMEOUT_CYCLES = NUM_TESTS * 64 + 100;

   // one table entry, program plus expected responses
   typedef struct packed {
      instr_t [MAX_WORDS-1:0] words;
      logic [4:0]             n_words;
      wb_t [MAX_WRITES-1:0]   writes;
      logic [3:0]             n_writes;
      addr_t                  final_pc;
   } test_t;

   logic  clk;
   logic  rst_n;
   logic  run;
   logic  load_we;
   addr_t load_addr;
   byte_t load_data;
   wb_t   wb;
   addr_t pc;

   test_t  tests [NUM_TESTS];
   integer seed = 76895;
   int     cur_test;

   chip8_core chip8_core_i (
      .clk       (clk),
      .rst_n     (rst_n),
      .run       (run),
      .load_we   (load_we),
      .load_addr (load_addr),
      .load_data (load_data),
      .wb        (wb),
      .pc        (pc)
   );

   initial
   begin
      clk = 1'b0;
      forever #10 clk = ~clk;
   end

   initial
   begin
      repeat (TIMEOUT_CYCLES) @(posedge clk);
      $display("timeout after %0d cycles, test %0d made no progress", TIMEOUT_CYCLES, cur_test);
      abort_run();
   end

   task automatic abort_run();
      $display("*** FAILED ***");
      $fatal(1, "simulation stopped on the first error");
   endtask

   task automatic advance_cycle();
      @(posedge clk);
      #2; // inputs change just after the edge
   endtask

   task automatic check_wb(input wb_t expected, input wb_t actual);
      if (actual !== expected)
      begin
         $display("** Error at %0t ns: wb expected idx=%h value=%h, got valid=%b idx=%h value=%h",
                  $time, expected.idx, expected.value, actual.valid, actual.idx, actual.value);
         abort_run();
      end
   endtask

   task automatic check_pc(input addr_t expected, input addr_t actual);
      if (actual !== expected)
      begin
         $display("** Error at %0t ns: pc expected %h, got %h", $time, expected, actual);
         abort_run();
      end
   endtask

   task automatic add_word(input int t, input instr_t word);
      tests[t].words[tests[t].n_words] = word;
      tests[t].n_words = tests[t].n_words + 5'd1;
   endtask

   task automatic add_write(input int t, input reg_idx_t dest, input byte_t value);
      tests[t].writes[tests[t].n_writes] = '{valid: 1'b1, idx: dest, value: value};
      tests[t].n_writes = tests[t].n_writes + 4'd1;
   endtask

   // jump to itself, the program ends here
   task automatic add_halt(input int t);
      addr_t here;
      here = PC_START + addr_t'(2 * tests[t].n_words);
      add_word(t, {4'h1, here});
      tests[t].final_pc = here;
   endtask

   task automatic build_table();
      byte_t a;
      byte_t b;
      byte_t c;
      foreach (tests[t])
      begin
         tests[t] = '0;
      end
      add_word(0, 16'h6312);
      add_word(0, 16'h73F5); // wraps, VF stays untouched
      add_halt(0);
      add_write(0, 4'h3, 8'h12);
      add_write(0, 4'h3, 8'h12 + 8'hF5);
      a = byte_t'($random(seed));
      b = byte_t'($random(seed));
      c = byte_t'($random(seed));
      add_word(1, {8'h6A, a});
      add_word(1, {8'h7A, b});
      add_word(1, {8'h7A, c});
      add_halt(1);
      add_write(1, 4'hA, a);
      add_write(1, 4'hA, a + b);
      add_write(1, 4'hA, a + b + c);
      add_word(2, 16'h613C);
      add_word(2, 16'h62A5);
      add_word(2, 16'h8310); // LD
      add_word(2, 16'h8321); // OR
      add_word(2, 16'h8322); // AND
      add_word(2, 16'h8313); // XOR
      add_halt(2);
      add_write(2, 4'h1, 8'h3C);
      add_write(2, 4'h2, 8'hA5);
      add_write(2, 4'h3, 8'h3C);
      add_write(2, 4'h3, 8'h3C | 8'hA5);
      add_write(2, 4'h3, (8'h3C | 8'hA5) & 8'hA5);
      add_write(2, 4'h3, ((8'h3C | 8'hA5) & 8'hA5) ^ 8'h3C);
      add_word(3, 16'h61F0);
      add_word(3, 16'h6220);
      add_word(3, 16'h8124); // ADD with carry
      add_word(3, 16'h8125); // SUB with borrow
      add_word(3, 16'h8217); // SUBN
      add_halt(3);
      add_write(3, 4'h1, 8'hF0);
      add_write(3, 4'h2, 8'h20);
      add_write(3, 4'h1, 8'hF0 + 8'h20);
      add_write(3, FLAG_REG, 8'h01);
      add_write(3, 4'h1, 8'h10 - 8'h20);
      add_write(3, FLAG_REG, 8'h00);
      add_write(3, 4'h2, 8'hF0 - 8'h20);
      add_write(3, FLAG_REG, 8'h01);
      add_word(4, 16'h6481);
      add_word(4, 16'h8406); // SHR
      add_word(4, 16'h840E); // SHL
      add_word(4, 16'h840E);
      add_halt(4);
      add_write(4, 4'h4, 8'h81);
      add_write(4, 4'h4, 8'h81 >> 1);
      add_write(4, FLAG_REG, 8'h01);
      add_write(4, 4'h4, 8'h40 << 1);
      add_write(4, FLAG_REG, 8'h00);
      add_write(4, 4'h4, 8'h80 << 1);
      add_write(4, FLAG_REG, 8'h01);
      add_word(5, 16'h6542);
      add_word(5, 16'h6642);
      add_word(5, 16'h3542); // SE taken
      add_word(5, 16'h6701);
      add_word(5, 16'h3500); // SE not taken
      add_word(5, 16'h6702);
      add_word(5, 16'h4500); // SNE taken
      add_word(5, 16'h6703);
      add_word(5, 16'h4542); // SNE not taken
      add_word(5, 16'h6704);
      add_word(5, 16'h5560); // SE reg taken
      add_word(5, 16'h6705);
      add_word(5, 16'h6611);
      add_word(5, 16'h5560); // SE reg not taken
      add_word(5, 16'h6706);
      add_halt(5);
      add_write(5, 4'h5, 8'h42);
      add_write(5, 4'h6, 8'h42);
      add_write(5, 4'h7, 8'h02);
      add_write(5, 4'h7, 8'h04);
      add_write(5, 4'h6, 8'h11);
      add_write(5, 4'h7, 8'h06);
      add_word(6, 16'h6801);
      add_word(6, 16'h2208);
      add_word(6, 16'h6803); // runs after both returns
      add_halt(6);
      add_word(6, 16'h6902);
      add_word(6, 16'h220E); // nested call
      add_word(6, 16'h00EE);
      add_word(6, 16'h6A04);
      add_word(6, 16'h00EE);
      add_write(6, 4'h8, 8'h01);
      add_write(6, 4'h9, 8'h02);
      add_write(6, 4'hA, 8'h04);
      add_write(6, 4'h8, 8'h03);
      add_word(7, 16'h6B07);
      add_word(7, 16'h1206);
      add_word(7, 16'h6B99); // jumped over
      add_word(7, 16'h7B01);
      add_word(7, 16'h00E0);
      add_word(7, 16'hA123); // dropped opcode, no-op
      add_halt(7);
      add_write(7, 4'hB, 8'h07);
      add_write(7, 4'hB, 8'h08);
   endtask

   task automatic run_test(input int t);
      int i;
      int seen_exec;
      cur_test = t;
      rst_n    = 1'b0;
      run      = 1'b0;
      repeat (2) advance_cycle();
      rst_n = 1'b1;
      for (i = 0; i < tests[t].n_words; i++)
      begin
         load_we   = 1'b1;
         load_addr = PC_START + addr_t'(2 * i);
         load_data = tests[t].words[i][15:8]; // high byte first
         advance_cycle();
         load_addr = load_addr + 12'd1;
         load_data = tests[t].words[i][7:0];
         advance_cycle();
      end
      load_we = 1'b0;
      run     = 1'b1;
      for (i = 0; i < tests[t].n_writes; i++)
      begin
         @(negedge clk);
         while (!wb.valid)
         begin
            @(negedge clk);
         end
         check_wb(tests[t].writes[i], wb);
      end
      repeat (QUIET_CYCLES)
      begin
         @(negedge clk);
         if (wb.valid)
         begin
            $display("test %0d wrote V%h after its last expected write", t, wb.idx);
            abort_run();
         end
      end
      // self-jump loop shows the jump address twice, then +2 in EXEC
      seen_exec = 0;
      repeat (3)
      begin
         @(negedge clk);
         if (pc == tests[t].final_pc + 12'd2)
         begin
            seen_exec++;
         end
         else
         begin
            check_pc(tests[t].final_pc, pc);
         end
      end
      if (seen_exec != 1)
      begin
         $display("test %0d: pc is not looping on the terminating jump", t);
         abort_run();
      end
      advance_cycle();
      run = 1'b0;
   endtask

   initial
   begin
      int t;
      rst_n     = 1'b0;
      run       = 1'b0;
      load_we   = 1'b0;
      load_addr = '0;
      load_data = '0;
      cur_test  = 0;
      build_table();
      for (t = 0; t < NUM_TESTS; t++)
      begin
         run_test(t);
      end
      $display("*** PASSED ***");
      $finish;
   end

endmodule
